// File: hw/pollable_memory_pkg.sv
// --------------------------------------------------
// shared constants and types for the pollable memory
// bus transfer widths, word types, memory request
// and the slave state encoding
// --------------------------------------------------

package pollable_memory_pkg;

	// --------------------------------------------------
	// bus geometry
	// one transfer on the parallel bus
	localparam int bus_width = 16;
	// transfers per memory word, high half first
	localparam int halves_per_word = 2;

	// --------------------------------------------------
	// vector types
	typedef logic [bus_width-1:0] bus_half_t;
	typedef logic [bus_width*halves_per_word-1:0] data_word_t;
	// upper bits pick the bank, lower bits the word in the bank
	typedef logic [bus_width-1:0] address_word_t;

	// word access from the slave toward the banks
	typedef struct packed {
		logic          write_strobe;
		logic          read_strobe;
		address_word_t address;
		data_word_t    write_data;
	} mem_request_t;

	// slave fsm
	typedef enum logic [2:0] {
		idle,
		address_write,
		address_read,
		data_write,
		data_fetch,
		data_read,
		wait_release
	} slave_state_t;

endpackage

// File: hw/reset_wait.sv
// --------------------------------------------------
// power-up reset stretcher
// holds reset for 2**RESET_WAIT_BITS clocks after arst_n
// --------------------------------------------------

module reset_wait #(
	parameter int RESET_WAIT_BITS = 23
) (
	input  logic clock100,
	input  logic arst_n,
	output logic reset
);

	// low bits count the wait, the extra top bit is the done flag
	logic [RESET_WAIT_BITS:0] count;

	// cleared asynchronously, so reset asserts at once
	always_ff @(posedge clock100 or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (!count[RESET_WAIT_BITS]) begin
			// freezes once the top bit sets
			count <= count + 1'b1;
		end
	end

	// released exactly when the wait has run out
	assign reset = !count[RESET_WAIT_BITS];

endmodule

// File: hw/half_duplex_bus_slave.sv
// --------------------------------------------------
// half-duplex parallel bus slave
// input synchronizer, transaction decode, address register,
// half-word assembly and the two-half read serializer
// --------------------------------------------------

module half_duplex_bus_slave #(
	parameter int ADDRESS_AUTOINCREMENT = 1
) (
	input  logic                              clock100,
	input  logic                              reset,
	input  pollable_memory_pkg::bus_half_t    bus_in,
	input  logic                              read,
	input  logic                              register_select,
	input  logic                              enable,
	output pollable_memory_pkg::bus_half_t    bus_out,
	output logic                              bus_oe,
	output logic                              ack_valid,
	output pollable_memory_pkg::mem_request_t request,
	input  pollable_memory_pkg::data_word_t   read_data
);

	localparam int half_bits = pollable_memory_pkg::bus_width;

	// everything the host drives, sampled as one bundle
	typedef struct packed {
		logic                           read;
		logic                           register_select;
		logic                           enable;
		pollable_memory_pkg::bus_half_t data;
	} bus_sample_t;

	bus_sample_t sample_meta;
	bus_sample_t sample;

	pollable_memory_pkg::slave_state_t  state;
	pollable_memory_pkg::address_word_t address;
	pollable_memory_pkg::bus_half_t     high_half;
	pollable_memory_pkg::data_word_t    write_data_q;
	pollable_memory_pkg::data_word_t    read_latch;

	logic write_strobe_q;
	// address bump one cycle after a finished word
	logic advance;
	// 0 expects the high half, 1 the low half
	logic second_half;
	// one extra cycle for the bank and select registers
	logic fetch_wait;

	logic start;
	logic address_write_start;
	logic address_read_start;
	logic data_write_start;
	logic data_read_first;
	logic data_read_second;
	logic fetch_done;
	logic acknowledge;
	logic present;
	logic release_done;

	// --------------------------------------------------
	// two-flop synchronizer
	always_ff @(posedge clock100) begin
		sample_meta <= '{
			read: read,
			register_select: register_select,
			enable: enable,
			data: bus_in
		};
		sample <= sample_meta;
	end

	// --------------------------------------------------
	// transaction decode
	always_comb begin
		// a new transaction only starts from idle
		start = (state == pollable_memory_pkg::idle) && sample.enable;
		address_write_start = start && !sample.register_select && !sample.read;
		address_read_start  = start && !sample.register_select && sample.read;
		data_write_start    = start && sample.register_select && !sample.read;
		data_read_first     = start && sample.register_select && sample.read && !second_half;
		data_read_second    = start && sample.register_select && sample.read && second_half;
		// read_data settled two cycles after the strobe
		fetch_done = (state == pollable_memory_pkg::data_fetch) && fetch_wait;
		acknowledge = address_write_start || address_read_start || data_write_start
			|| data_read_second || fetch_done;
		// drive the bus only for reads
		present = address_read_start || data_read_second || fetch_done;
		// host let go of enable
		release_done = (state == pollable_memory_pkg::wait_release) && !sample.enable;
	end

	// --------------------------------------------------
	// control state
	always_ff @(posedge clock100) begin
		if (reset) begin
			state          <= pollable_memory_pkg::idle;
			ack_valid      <= 1'b0;
			bus_oe         <= 1'b0;
			write_strobe_q <= 1'b0;
			advance        <= 1'b0;
			second_half    <= 1'b0;
			fetch_wait     <= 1'b0;
			address        <= '0;
		end else begin
			// write goes out once both halves are in
			write_strobe_q <= data_write_start && second_half;
			advance <= (ADDRESS_AUTOINCREMENT != 0)
				&& ((data_write_start && second_half) || data_read_second);
			fetch_wait <= (state == pollable_memory_pkg::data_fetch) && !fetch_wait;
			// address register, host load wins
			if (address_write_start) begin
				address <= sample.data;
			end else if (advance) begin
				address <= address + 1'b1;
			end
			// half counter, restarted by any address write
			if (address_write_start) begin
				second_half <= 1'b0;
			end else if (data_write_start) begin
				second_half <= !second_half;
			end else if (fetch_done) begin
				second_half <= 1'b1;
			end else if (data_read_second) begin
				second_half <= 1'b0;
			end
			// level handshake, held until enable drops
			if (acknowledge) begin
				ack_valid <= 1'b1;
			end else if (release_done) begin
				ack_valid <= 1'b0;
			end
			if (present) begin
				bus_oe <= 1'b1;
			end else if (release_done) begin
				bus_oe <= 1'b0;
			end
			case (state)
				pollable_memory_pkg::idle: begin
					if (address_write_start) begin
						state <= pollable_memory_pkg::address_write;
					end else if (address_read_start) begin
						state <= pollable_memory_pkg::address_read;
					end else if (data_write_start) begin
						state <= pollable_memory_pkg::data_write;
					end else if (data_read_first) begin
						state <= pollable_memory_pkg::data_fetch;
					end else if (data_read_second) begin
						state <= pollable_memory_pkg::data_read;
					end
				end
				pollable_memory_pkg::data_fetch: begin
					if (fetch_wait) begin
						state <= pollable_memory_pkg::data_read;
					end
				end
				// one cycle each, then wait for the host
				pollable_memory_pkg::address_write,
				pollable_memory_pkg::address_read,
				pollable_memory_pkg::data_write,
				pollable_memory_pkg::data_read: begin
					state <= pollable_memory_pkg::wait_release;
				end
				pollable_memory_pkg::wait_release: begin
					if (!sample.enable) begin
						state <= pollable_memory_pkg::idle;
					end
				end
				default: begin
					state <= pollable_memory_pkg::idle;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// datapath, big endian halves
	always_ff @(posedge clock100) begin
		if (address_read_start) begin
			bus_out <= address;
		end else if (data_read_second) begin
			bus_out <= read_latch[half_bits-1:0];
		end else if (fetch_done) begin
			bus_out <= read_data[2*half_bits-1:half_bits];
		end
		// both halves come from one fetched word
		if (fetch_done) begin
			read_latch <= read_data;
		end
		if (data_write_start && !second_half) begin
			high_half <= sample.data;
		end
		if (data_write_start && second_half) begin
			write_data_q <= {high_half, sample.data};
		end
	end

	// read strobe leaves straight from the decode
	always_comb begin
		request.write_strobe = write_strobe_q;
		request.read_strobe  = data_read_first;
		request.address      = address;
		request.write_data   = write_data_q;
	end

	// --------------------------------------------------
	// protocol checks
	strobes_exclusive: assert property (@(posedge clock100) disable iff (reset)
		!(request.write_strobe && request.read_strobe))
		else $error("write and read strobe together");

	// ack only answers a host that is still asking
	ack_needs_enable: assert property (@(posedge clock100) disable iff (reset)
		$rose(ack_valid) |-> $past(enable))
		else $error("ack_valid rose with enable low");

endmodule

// File: hw/memory_bank.sv
// --------------------------------------------------
// single-port bank of 32-bit words
// synchronous write, registered read
// --------------------------------------------------

module memory_bank #(
	parameter int BANK_ADDRESS_DEPTH = 13
) (
	input  logic                            clock100,
	input  logic                            write_enable,
	input  logic                            read_enable,
	input  logic [BANK_ADDRESS_DEPTH-1:0]   address,
	input  pollable_memory_pkg::data_word_t write_data,
	output pollable_memory_pkg::data_word_t read_data
);

	localparam int words = 2 ** BANK_ADDRESS_DEPTH;

	// maps onto block ram
	pollable_memory_pkg::data_word_t mem [words];

	always_ff @(posedge clock100) begin
		if (write_enable) begin
			mem[address] <= write_data;
		end
		// output register holds until the next read
		if (read_enable) begin
			read_data <= mem[address];
		end
	end

	// --------------------------------------------------
	// single port, the slave never asks for both
	one_access: assert property (@(posedge clock100)
		!(write_enable && read_enable))
		else $error("bank write and read in the same cycle");

endmodule

// File: hw/pollable_memory.sv
// --------------------------------------------------
// pollable memory top level
// reset wait, bus slave, banks, bank decode,
// read select and the out-of-range counter
// --------------------------------------------------

module pollable_memory #(
	parameter int BANK_ADDRESS_DEPTH    = 13,
	parameter int NUMBER_OF_BANKS       = 2,
	parameter int ADDRESS_AUTOINCREMENT = 1,
	parameter int RESET_WAIT_BITS       = 23
) (
	input  logic                           clock100,
	input  logic                           arst_n,
	input  pollable_memory_pkg::bus_half_t bus_in,
	input  logic                           read,
	input  logic                           register_select,
	input  logic                           enable,
	output pollable_memory_pkg::bus_half_t bus_out,
	output logic                           bus_oe,
	output logic                           ack_valid,
	output logic [7:0]                     address_errors
);

	localparam int bank_select_bits = pollable_memory_pkg::bus_width - BANK_ADDRESS_DEPTH;

	logic reset;
	pollable_memory_pkg::mem_request_t request;
	pollable_memory_pkg::data_word_t   read_data;
	pollable_memory_pkg::data_word_t   selected;
	pollable_memory_pkg::data_word_t   bank_data [NUMBER_OF_BANKS];
	logic [NUMBER_OF_BANKS-1:0]        bank_write;
	logic [NUMBER_OF_BANKS-1:0]        bank_read;
	logic [bank_select_bits-1:0]       bank;
	// bank of the read in flight
	logic [bank_select_bits-1:0]       read_bank;
	logic                              in_range;

	reset_wait #(.RESET_WAIT_BITS(RESET_WAIT_BITS)) reset_wait_i (
		.clock100(clock100), .arst_n(arst_n), .reset(reset)
	);

	half_duplex_bus_slave #(.ADDRESS_AUTOINCREMENT(ADDRESS_AUTOINCREMENT)) slave_i (
		.clock100(clock100), .reset(reset),
		.bus_in(bus_in), .read(read), .register_select(register_select), .enable(enable),
		.bus_out(bus_out), .bus_oe(bus_oe), .ack_valid(ack_valid),
		.request(request), .read_data(read_data)
	);

	// --------------------------------------------------
	// bank decode from the upper address bits
	assign bank     = request.address[pollable_memory_pkg::bus_width-1:BANK_ADDRESS_DEPTH];
	assign in_range = int'(bank) < NUMBER_OF_BANKS;

	for (genvar i = 0; i < NUMBER_OF_BANKS; i++) begin : banks
		// strobes only reach the addressed bank
		assign bank_write[i] = request.write_strobe && (bank == bank_select_bits'(i));
		assign bank_read[i]  = request.read_strobe && (bank == bank_select_bits'(i));
		memory_bank #(.BANK_ADDRESS_DEPTH(BANK_ADDRESS_DEPTH)) bank_i (
			.clock100(clock100),
			.write_enable(bank_write[i]), .read_enable(bank_read[i]),
			.address(request.address[BANK_ADDRESS_DEPTH-1:0]),
			.write_data(request.write_data), .read_data(bank_data[i])
		);
	end

	// missing banks read as zero
	always_comb begin
		selected = '0;
		for (int b = 0; b < NUMBER_OF_BANKS; b++) begin
			if (read_bank == bank_select_bits'(b)) begin
				selected = bank_data[b];
			end
		end
	end

	// --------------------------------------------------
	// select register, second cycle of the read latency
	always_ff @(posedge clock100) begin
		if (request.read_strobe) begin
			read_bank <= bank;
		end
		read_data <= selected;
	end

	// saturating count of strobes to absent banks
	always_ff @(posedge clock100) begin
		if (reset) begin
			address_errors <= '0;
		end else if ((request.write_strobe || request.read_strobe) && !in_range
			&& (address_errors != 8'hff)) begin
			address_errors <= address_errors + 1'b1;
		end
	end

endmodule

// File: testbench/tb_pollable_memory.sv
// --------------------------------------------------
// testbench for the pollable memory
// clock, reset, bus handshake tasks, word helpers,
// directed tests and the closing report
// --------------------------------------------------

module tb_pollable_memory;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ack_timeout = 200;

	logic clock100 = 1'b0;
	logic arst_n;
	pollable_memory_pkg::bus_half_t bus_in;
	logic read;
	logic register_select;
	logic enable;
	pollable_memory_pkg::bus_half_t bus_out;
	logic bus_oe;
	logic ack_valid;
	logic [7:0] address_errors;

	// expected memory contents by full address
	pollable_memory_pkg::data_word_t scoreboard [pollable_memory_pkg::address_word_t];

	integer seed = 32'ha2a6;
	int check_errors = 0;
	int timeout_errors = 0;
	// set once a handshake hangs, later bus calls are skipped
	logic timed_out = 1'b0;

	pollable_memory #(.RESET_WAIT_BITS(4)) dut_i (
		.clock100(clock100), .arst_n(arst_n),
		.bus_in(bus_in), .read(read), .register_select(register_select), .enable(enable),
		.bus_out(bus_out), .bus_oe(bus_oe), .ack_valid(ack_valid),
		.address_errors(address_errors)
	);

	// 125 MHz is close enough for the model
	always #4 clock100 = ~clock100;

	// --------------------------------------------------
	// handshake primitives
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		// sampled 1 ns after the edge, where ack_valid is settled
		while (ack_valid !== level && cycles < ack_timeout) begin
			@(posedge clock100);
			#1;
			cycles++;
		end
		if (ack_valid !== level) begin
			timed_out = 1'b1;
			timeout_errors++;
			$display("timeout waiting for ack_valid to go %s, slave stuck in state %s",
				level ? "high" : "low", dut_i.slave_i.state.name());
		end
	endtask

	task automatic bus_write(input logic select, input pollable_memory_pkg::bus_half_t value);
		if (timed_out) return;
		@(posedge clock100);
		#1;
		read = 1'b0;
		register_select = select;
		bus_in = value;
		// controls settle a cycle before enable
		@(posedge clock100);
		#1;
		enable = 1'b1;
		wait_ack(1'b1);
		if (bus_oe !== 1'b0) begin
			check_errors++;
			$display("CHECK FAILED bus_oe during write: expected %h, got %h", 1'b0, bus_oe);
		end
		enable = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic bus_read(input logic select, output pollable_memory_pkg::bus_half_t value);
		value = 'x;
		if (timed_out) return;
		@(posedge clock100);
		#1;
		read = 1'b1;
		register_select = select;
		@(posedge clock100);
		#1;
		enable = 1'b1;
		wait_ack(1'b1);
		value = bus_out;
		if (bus_oe !== 1'b1) begin
			check_errors++;
			$display("CHECK FAILED bus_oe during read: expected %h, got %h", 1'b1, bus_oe);
		end
		enable = 1'b0;
		wait_ack(1'b0);
		// bus released together with ack_valid
		if (bus_oe !== 1'b0) begin
			check_errors++;
			$display("CHECK FAILED bus_oe after read: expected %h, got %h", 1'b0, bus_oe);
		end
	endtask

	// --------------------------------------------------
	// word helpers, high half first
	task automatic set_address(input pollable_memory_pkg::address_word_t address);
		bus_write(1'b0, address);
	endtask

	task automatic write_halves(input pollable_memory_pkg::data_word_t word);
		bus_write(1'b1, word[31:16]);
		bus_write(1'b1, word[15:0]);
	endtask

	task automatic read_halves(output pollable_memory_pkg::data_word_t word);
		pollable_memory_pkg::bus_half_t high;
		pollable_memory_pkg::bus_half_t low;
		bus_read(1'b1, high);
		bus_read(1'b1, low);
		word = {high, low};
	endtask

	task automatic compare_word(input string signal, input pollable_memory_pkg::data_word_t expected,
		input pollable_memory_pkg::data_word_t got);
		if (got !== expected) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %h, got %h", signal, expected, got);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	task automatic check_reset_state();
		if (ack_valid !== 1'b0) begin
			check_errors++;
			$display("CHECK FAILED ack_valid: expected %h, got %h", 1'b0, ack_valid);
		end
		if (bus_oe !== 1'b0) begin
			check_errors++;
			$display("CHECK FAILED bus_oe: expected %h, got %h", 1'b0, bus_oe);
		end
		if (address_errors !== 8'h00) begin
			check_errors++;
			$display("CHECK FAILED address_errors: expected %h, got %h", 8'h00, address_errors);
		end
	endtask

	task automatic address_register_roundtrip();
		pollable_memory_pkg::bus_half_t got;
		set_address(16'h1abc);
		bus_read(1'b0, got);
		if (got !== 16'h1abc) begin
			check_errors++;
			$display("CHECK FAILED bus_out address: expected %h, got %h", 16'h1abc, got);
		end
	endtask

	task automatic single_word_access();
		pollable_memory_pkg::data_word_t word;
		pollable_memory_pkg::bus_half_t high;
		pollable_memory_pkg::bus_half_t low;
		word = $random(seed);
		set_address(16'h0123);
		write_halves(word);
		scoreboard[16'h0123] = word;
		// auto-increment moved on, so point back
		set_address(16'h0123);
		bus_read(1'b1, high);
		bus_read(1'b1, low);
		if (high !== word[31:16]) begin
			check_errors++;
			$display("CHECK FAILED bus_out high half: expected %h, got %h", word[31:16], high);
		end
		if (low !== word[15:0]) begin
			check_errors++;
			$display("CHECK FAILED bus_out low half: expected %h, got %h", word[15:0], low);
		end
	endtask

	task automatic autoincrement_sequence();
		pollable_memory_pkg::address_word_t address;
		pollable_memory_pkg::bus_half_t got_address;
		pollable_memory_pkg::data_word_t word;
		address = 16'h0040;
		set_address(address);
		for (int i = 0; i < 4; i++) begin
			word = $random(seed);
			write_halves(word);
			scoreboard[address] = word;
			address = address + 16'd1;
		end
		// four words written, register sits past them
		bus_read(1'b0, got_address);
		if (got_address !== 16'h0044) begin
			check_errors++;
			$display("CHECK FAILED bus_out address: expected %h, got %h", 16'h0044, got_address);
		end
		address = 16'h0040;
		set_address(address);
		for (int i = 0; i < 4; i++) begin
			read_halves(word);
			compare_word("read_data sequential", scoreboard[address], word);
			address = address + 16'd1;
		end
	endtask

	task automatic bank_separation();
		pollable_memory_pkg::data_word_t first;
		pollable_memory_pkg::data_word_t second;
		pollable_memory_pkg::data_word_t got;
		first = $random(seed);
		second = ~first;
		set_address(16'h0010);
		write_halves(first);
		scoreboard[16'h0010] = first;
		// same word index, bank 1
		set_address(16'h2010);
		write_halves(second);
		scoreboard[16'h2010] = second;
		set_address(16'h0010);
		read_halves(got);
		compare_word("read_data bank 0", scoreboard[16'h0010], got);
		set_address(16'h2010);
		read_halves(got);
		compare_word("read_data bank 1", scoreboard[16'h2010], got);
	endtask

	task automatic out_of_range_bank();
		logic [7:0] errors_before;
		pollable_memory_pkg::data_word_t word;
		pollable_memory_pkg::data_word_t got;
		errors_before = address_errors;
		word = $random(seed);
		// bank 5 is not built
		set_address(16'ha010);
		write_halves(word);
		if (address_errors !== errors_before + 8'd1) begin
			check_errors++;
			$display("CHECK FAILED address_errors after write: expected %h, got %h",
				errors_before + 8'd1, address_errors);
		end
		// the dropped write must not alias into a real bank
		set_address(16'h0010);
		read_halves(got);
		compare_word("read_data bank 0 after bank 5 write", scoreboard[16'h0010], got);
		set_address(16'h2010);
		read_halves(got);
		compare_word("read_data bank 1 after bank 5 write", scoreboard[16'h2010], got);
		set_address(16'ha010);
		read_halves(got);
		compare_word("read_data bank 5", 32'h0000_0000, got);
		if (address_errors !== errors_before + 8'd2) begin
			check_errors++;
			$display("CHECK FAILED address_errors after read: expected %h, got %h",
				errors_before + 8'd2, address_errors);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	initial begin
		arst_n = 1'b0;
		bus_in = '0;
		read = 1'b0;
		register_select = 1'b0;
		enable = 1'b0;
		repeat (3) @(posedge clock100);
		#1;
		arst_n = 1'b1;
		wait_ack(1'b0);
		// reset_wait still holds the logic for 16 cycles
		repeat (24) @(posedge clock100);
		#1;
		check_reset_state();
		address_register_roundtrip();
		single_word_access();
		autoincrement_sequence();
		bank_separation();
		out_of_range_bank();
		$display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: project.f
hw/pollable_memory_pkg.sv
hw/reset_wait.sv
hw/half_duplex_bus_slave.sv
hw/memory_bank.sv
hw/pollable_memory.sv
testbench/tb_pollable_memory.sv

// File: Makefile
# Verilator flow for the pollable memory

TB_TOP = tb_pollable_memory

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module pollable_memory
	verilator --lint-only --timing --assert -f project.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
